// ==== logic/fc_pkg.sv ====
package fc_pkg;

	// Node and weight word width
	localparam int DATA_W = 8;

	// Per-core result, wraps modulo 2^ACC_W
	localparam int ACC_W = 4 * DATA_W;

	// Block memory depth is 2^ADDR_W words
	localparam int ADDR_W = 12;

	// One bit wider than the address so a full memory count fits
	localparam int CNT_W = ADDR_W + 1;

	localparam int DEF_NUM_CORES = 4;

	// Shared by the read and the write FSM
	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_RUN  = 2'd1,
		ST_DONE = 2'd2
	} mover_state_t;

endpackage

// ==== logic/fc_mac_core.sv ====
`timescale 1ns/100ps

module fc_mac_core (
	input  logic                      clk,
	input  logic                      reset_n,
	input  logic                      i_run,
	input  logic                      i_valid,
	input  logic [fc_pkg::DATA_W-1:0] i_node,
	input  logic [fc_pkg::DATA_W-1:0] i_wgt,
	output logic [fc_pkg::ACC_W-1:0]  o_result,
	output logic                      o_valid
);

	logic [2*fc_pkg::DATA_W-1:0] product;
	logic [fc_pkg::ACC_W-1:0]    product_ext;
	logic [fc_pkg::ACC_W-1:0]    acc;
	logic                        valid_q;

	// Unsigned 8x8 multiply
	assign product     = i_node * i_wgt;
	assign product_ext = {{(fc_pkg::ACC_W - 2*fc_pkg::DATA_W){1'b0}}, product};

	// Accumulator, cleared at the start of every job
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			acc <= '0;
		end else if (i_run) begin
			acc <= '0;
		end else if (i_valid) begin
			acc <= acc + product_ext;   // Wraps on overflow
		end
	end

	// One cycle core latency
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= i_valid;
		end
	end

	assign o_result = acc;
	assign o_valid  = valid_q;

	// The start pulse must never meet data still in flight
	assert property (@(posedge clk) disable iff (!reset_n)
		!(i_run && i_valid))
		else $error("fc_mac_core: i_run while data valid");

endmodule

// ==== logic/fc_mover_ctrl.sv ====
`timescale 1ns/100ps

module fc_mover_ctrl #(
	parameter int NUM_CORES = fc_pkg::DEF_NUM_CORES
) (
	input  logic                      clk,
	input  logic                      reset_n,
	input  logic                      i_run,
	input  logic [fc_pkg::CNT_W-1:0]  i_num_cnt,
	input  logic [NUM_CORES-1:0]      i_core_valid,
	output logic                      o_idle,
	output logic                      o_read,
	output logic                      o_write,
	output logic                      o_done,
	output logic [fc_pkg::ADDR_W-1:0] o_rd_addr
);

	fc_pkg::mover_state_t rd_state;
	fc_pkg::mover_state_t rd_state_nxt;
	fc_pkg::mover_state_t wr_state;
	fc_pkg::mover_state_t wr_state_nxt;

	logic [fc_pkg::CNT_W-1:0] num_cnt;
	logic [fc_pkg::CNT_W-1:0] last_idx;
	logic [fc_pkg::CNT_W-1:0] rd_cnt;
	logic [fc_pkg::CNT_W-1:0] wr_cnt;
	logic                     all_valid;
	logic                     rd_last;
	logic                     wr_last;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			rd_state <= fc_pkg::ST_IDLE;
			wr_state <= fc_pkg::ST_IDLE;
		end else begin
			rd_state <= rd_state_nxt;
			wr_state <= wr_state_nxt;
		end
	end

	// Read side runs one address per cycle
	always_comb begin
		rd_state_nxt = rd_state;
		case (rd_state)
			fc_pkg::ST_IDLE: if (i_run) rd_state_nxt = fc_pkg::ST_RUN;
			fc_pkg::ST_RUN:  if (rd_last) rd_state_nxt = fc_pkg::ST_DONE;
			fc_pkg::ST_DONE: rd_state_nxt = fc_pkg::ST_IDLE;
			default:         rd_state_nxt = fc_pkg::ST_IDLE;
		endcase
	end

	// Write side trails the read side by the pipeline depth
	always_comb begin
		wr_state_nxt = wr_state;
		case (wr_state)
			fc_pkg::ST_IDLE: if (i_run) wr_state_nxt = fc_pkg::ST_RUN;
			fc_pkg::ST_RUN:  if (wr_last) wr_state_nxt = fc_pkg::ST_DONE;
			fc_pkg::ST_DONE: wr_state_nxt = fc_pkg::ST_IDLE;
			default:         wr_state_nxt = fc_pkg::ST_IDLE;
		endcase
	end

	assign o_idle  = (rd_state == fc_pkg::ST_IDLE) && (wr_state == fc_pkg::ST_IDLE);
	assign o_read  = (rd_state == fc_pkg::ST_RUN);
	assign o_write = (wr_state == fc_pkg::ST_RUN);
	assign o_done  = (wr_state == fc_pkg::ST_DONE);   // Write side finishes last

	// Item count held for the whole job
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			num_cnt <= '0;
		end else if (i_run) begin
			num_cnt <= i_num_cnt;
		end else if (o_done) begin
			num_cnt <= '0;
		end
	end

	assign last_idx  = num_cnt - 1'b1;
	assign all_valid = &i_core_valid;
	assign rd_last   = o_read && (rd_cnt == last_idx);
	assign wr_last   = o_write && all_valid && (wr_cnt == last_idx);

	// Read address counter
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			rd_cnt <= '0;
		end else if (rd_last) begin
			rd_cnt <= '0;
		end else if (o_read) begin
			rd_cnt <= rd_cnt + 1'b1;
		end
	end

	// Counts results coming back from the cores
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			wr_cnt <= '0;
		end else if (wr_last) begin
			wr_cnt <= '0;
		end else if (o_write && all_valid) begin
			wr_cnt <= wr_cnt + 1'b1;
		end
	end

	// Count never exceeds the memory depth, top bit not needed
	assign o_rd_addr = rd_cnt[fc_pkg::ADDR_W-1:0];

	assert property (@(posedge clk) disable iff (!reset_n)
		i_run |-> o_idle)
		else $error("fc_mover_ctrl: i_run while busy");

	assert property (@(posedge clk) disable iff (!reset_n)
		i_run |-> (i_num_cnt != '0))
		else $error("fc_mover_ctrl: zero count at i_run");

	// Read side must already be back in idle when the write side ends
	assert property (@(posedge clk) disable iff (!reset_n)
		o_done |=> (!o_done && o_idle))
		else $error("fc_mover_ctrl: o_done not a single pulse followed by idle");

endmodule

// ==== logic/fc_layer_top.sv ====
`timescale 1ns/100ps

module fc_layer_top #(
	parameter int NUM_CORES = fc_pkg::DEF_NUM_CORES
) (
	input  logic                                clk,
	input  logic                                reset_n,
	input  logic                                i_run,
	input  logic [fc_pkg::CNT_W-1:0]            i_num_cnt,
	output logic                                o_idle,
	output logic                                o_read,
	output logic                                o_write,
	output logic                                o_done,

	// Node memory
	output logic [fc_pkg::ADDR_W-1:0]           o_node_addr,
	output logic                                o_node_ce,
	input  logic [fc_pkg::DATA_W-1:0]           i_node_q,

	// Weight memories, one per core, shared address
	output logic [fc_pkg::ADDR_W-1:0]           o_wgt_addr,
	output logic                                o_wgt_ce,
	input  logic [NUM_CORES*fc_pkg::DATA_W-1:0] i_wgt_q,

	output logic [NUM_CORES*fc_pkg::ACC_W-1:0]  o_result
);

	logic [fc_pkg::ADDR_W-1:0] rd_addr;
	logic                      read_en;
	logic                      rd_valid;
	logic [NUM_CORES-1:0]      core_valid;

	fc_mover_ctrl #(
		.NUM_CORES (NUM_CORES)
	) u_ctrl (
		.clk          (clk),
		.reset_n      (reset_n),
		.i_run        (i_run),
		.i_num_cnt    (i_num_cnt),
		.i_core_valid (core_valid),
		.o_idle       (o_idle),
		.o_read       (read_en),
		.o_write      (o_write),
		.o_done       (o_done),
		.o_rd_addr    (rd_addr)
	);

	assign o_read      = read_en;
	assign o_node_addr = rd_addr;
	assign o_node_ce   = read_en;
	assign o_wgt_addr  = rd_addr;
	assign o_wgt_ce    = read_en;

	// Memory read latency, lines up valid with q
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= read_en;
		end
	end

	// Node word is broadcast, each core gets its own weight slice
	for (genvar g = 0; g < NUM_CORES; g++) begin : g_core
		fc_mac_core u_core (
			.clk      (clk),
			.reset_n  (reset_n),
			.i_run    (i_run),
			.i_valid  (rd_valid),
			.i_node   (i_node_q),
			.i_wgt    (i_wgt_q[g*fc_pkg::DATA_W +: fc_pkg::DATA_W]),
			.o_result (o_result[g*fc_pkg::ACC_W +: fc_pkg::ACC_W]),
			.o_valid  (core_valid[g])
		);
	end

endmodule

// ==== verification/fc_bram_model.sv ====
`timescale 1ns/100ps

module fc_bram_model #(
	parameter int DATA_W = 8,
	parameter int ADDR_W = 12
) (
	input  logic              clk,
	input  logic              i_we,
	input  logic [ADDR_W-1:0] i_waddr,
	input  logic [DATA_W-1:0] i_wdata,
	input  logic              i_ce,
	input  logic [ADDR_W-1:0] i_addr,
	output logic [DATA_W-1:0] o_q
);

	logic [DATA_W-1:0] mem [0:(1<<ADDR_W)-1];

	// Load port, only used while the DUT is idle
	always @(posedge clk) begin
		if (i_we) begin
			mem[i_waddr] <= i_wdata;
		end
	end

	// Block RAM style read, q one cycle after an enabled address
	always @(posedge clk) begin
		if (i_ce) begin
			o_q <= mem[i_addr];
		end
	end

endmodule

// ==== verification/fc_layer_tb.sv ====
`timescale 1ns/100ps

module fc_layer_tb;

	localparam int NUM_CORES = fc_pkg::DEF_NUM_CORES;
	localparam int DATA_W    = fc_pkg::DATA_W;
	localparam int ACC_W     = fc_pkg::ACC_W;
	localparam int ADDR_W    = fc_pkg::ADDR_W;
	localparam int CNT_W     = fc_pkg::CNT_W;
	localparam int DEPTH     = 1 << ADDR_W;
	localparam int DRIVE_DLY = 2;   // ns after the rising edge

	logic                          clk;
	logic                          reset_n;
	logic                          run;
	logic [CNT_W-1:0]              num_cnt;
	logic                          idle;
	logic                          read;
	logic                          write;
	logic                          done;
	logic [ADDR_W-1:0]             node_addr;
	logic                          node_ce;
	logic [DATA_W-1:0]             node_q;
	logic [ADDR_W-1:0]             wgt_addr;
	logic                          wgt_ce;
	logic [NUM_CORES*DATA_W-1:0]   wgt_q;
	logic [NUM_CORES*ACC_W-1:0]    result;

	// Memory load port shared by all models
	logic                          load_we;
	logic [ADDR_W-1:0]             load_addr;
	logic [DATA_W-1:0]             load_node;
	logic [NUM_CORES*DATA_W-1:0]   load_wgt;

	// Images of the memory contents for the reference
	logic [DATA_W-1:0] node_img [DEPTH];
	logic [DATA_W-1:0] wgt_img [NUM_CORES][DEPTH];

	logic [31:0]      lcg_state;
	logic [ACC_W-1:0] exp_val;
	logic [ACC_W-1:0] got_val;
	int edge_cnt = 0;
	int start_edge;
	int cur_n;
	int rd_seen;
	int done_seen;
	int n_pick;
	logic idle_check;
	logic in_job;
	logic exp_write;
	logic timed_out;
	int value_errs;
	int timing_errs;
	int timeout_errs;

	fc_layer_top #(
		.NUM_CORES (NUM_CORES)
	) uut (
		.clk         (clk),
		.reset_n     (reset_n),
		.i_run       (run),
		.i_num_cnt   (num_cnt),
		.o_idle      (idle),
		.o_read      (read),
		.o_write     (write),
		.o_done      (done),
		.o_node_addr (node_addr),
		.o_node_ce   (node_ce),
		.i_node_q    (node_q),
		.o_wgt_addr  (wgt_addr),
		.o_wgt_ce    (wgt_ce),
		.i_wgt_q     (wgt_q),
		.o_result    (result)
	);

	fc_bram_model #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) node_mem (
		.clk     (clk),
		.i_we    (load_we),
		.i_waddr (load_addr),
		.i_wdata (load_node),
		.i_ce    (node_ce),
		.i_addr  (node_addr),
		.o_q     (node_q)
	);

	for (genvar g = 0; g < NUM_CORES; g++) begin : g_wgt_mem
		fc_bram_model #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) u_mem (
			.clk     (clk),
			.i_we    (load_we),
			.i_waddr (load_addr),
			.i_wdata (load_wgt[g*DATA_W +: DATA_W]),
			.i_ce    (wgt_ce),
			.i_addr  (wgt_addr),
			.o_q     (wgt_q[g*DATA_W +: DATA_W])
		);
	end

	always #20 clk = ~clk;

	always @(posedge clk) begin
		edge_cnt <= edge_cnt + 1;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Sum of node times weight over the first n addresses, wraps at 2^32
	function automatic logic [ACC_W-1:0] ref_dot(input int core, input int n);
		logic [ACC_W-1:0] sum;
		sum = '0;
		for (int a = 0; a < n; a++) begin
			sum = sum + ACC_W'(node_img[a]) * ACC_W'(wgt_img[core][a]);
		end
		return sum;
	endfunction

	// Compare process, samples on the falling edge where outputs are stable
	always @(negedge clk) begin
		if (reset_n) begin
			if (run) begin
				start_edge = edge_cnt + 1;   // Edge that samples i_run
				rd_seen    = 0;
				done_seen  = 0;
				idle_check = 1'b0;
				in_job     = 1'b1;
			end
			// Write side busy from the start edge until o_done rises
			exp_write = in_job && (edge_cnt >= start_edge)
				&& (edge_cnt < start_edge + cur_n + 2);
			assert (write == exp_write) else begin
				timing_errs++;
				$display("error: o_write = 0x%0h, expected 0x%0h", write, exp_write);
			end
			assert (node_ce == read && wgt_ce == read) else begin
				timing_errs++;
				$display("Memory enables do not follow o_read at edge %0d", edge_cnt);
			end
			if (read) begin
				assert (node_addr == ADDR_W'(rd_seen)) else begin
					value_errs++;
					$display("error: o_node_addr = 0x%03h, expected 0x%03h",
						node_addr, ADDR_W'(rd_seen));
				end
				assert (wgt_addr == ADDR_W'(rd_seen)) else begin
					value_errs++;
					$display("error: o_wgt_addr = 0x%03h, expected 0x%03h",
						wgt_addr, ADDR_W'(rd_seen));
				end
				rd_seen++;
			end
			if (idle_check) begin
				assert (idle) else begin
					timing_errs++;
					$display("o_idle was not high in the cycle after o_done");
				end
				idle_check = 1'b0;
			end
			if (done) begin
				done_seen++;
				idle_check = 1'b1;
				in_job     = 1'b0;
				assert (edge_cnt == start_edge + cur_n + 2) else begin
					timing_errs++;
					$display("o_done rose %0d edges after i_run, expected %0d",
						edge_cnt - start_edge, cur_n + 2);
				end
				assert (rd_seen == cur_n) else begin
					timing_errs++;
					$display("o_read was high for %0d cycles, expected %0d", rd_seen, cur_n);
				end
				for (int c = 0; c < NUM_CORES; c++) begin
					exp_val = ref_dot(c, cur_n);
					got_val = result[c*ACC_W +: ACC_W];
					assert (got_val == exp_val) else begin
						value_errs++;
						$display("error: o_result[%0d] = 0x%08h, expected 0x%08h",
							c, got_val, exp_val);
					end
				end
			end
		end
	end

	// Fresh random contents for addresses 0 to n-1
	task automatic load_memories(input int n);
		logic [NUM_CORES*DATA_W-1:0] wvec;
		for (int a = 0; a < n; a++) begin
			lcg_state = lcg_next(lcg_state);
			node_img[a] = lcg_state[31:24];
			for (int c = 0; c < NUM_CORES; c++) begin
				lcg_state = lcg_next(lcg_state);
				wgt_img[c][a] = lcg_state[31:24];
				wvec[c*DATA_W +: DATA_W] = lcg_state[31:24];
			end
			load_we   = 1'b1;
			load_addr = ADDR_W'(a);
			load_node = node_img[a];
			load_wgt  = wvec;
			@(posedge clk);
			#DRIVE_DLY;
		end
		load_we = 1'b0;
	endtask

	task automatic run_job(input int n);
		int cycles;
		load_memories(n);
		cur_n   = n;
		num_cnt = CNT_W'(n);
		run     = 1'b1;
		@(posedge clk);
		#DRIVE_DLY;
		run = 1'b0;
		cycles = 0;
		while (done_seen == 0 && cycles < n + 20) begin
			@(posedge clk);
			#DRIVE_DLY;
			cycles++;
		end
		if (done_seen == 0) begin
			timeout_errs++;
			timed_out = 1'b1;
			$display("Timeout: no o_done within %0d cycles for a count of %0d", n + 20, n);
		end else begin
			cycles = 0;
			while (!idle && cycles < 20) begin
				@(posedge clk);
				#DRIVE_DLY;
				cycles++;
			end
			if (!idle) begin
				timeout_errs++;
				timed_out = 1'b1;
				$display("Timeout: o_idle did not return after o_done");
			end
			repeat (2) @(posedge clk);   // Room for a stray second pulse
			#DRIVE_DLY;
			assert (done_seen == 1) else begin
				timing_errs++;
				$display("o_done pulsed %0d times in one job", done_seen);
			end
		end
	endtask

	initial begin
		clk          = 1'b0;
		reset_n      = 1'b0;
		run          = 1'b0;
		num_cnt      = '0;
		load_we      = 1'b0;
		load_addr    = '0;
		load_node    = '0;
		load_wgt     = '0;
		lcg_state    = 32'ha7d1_70fd;
		timed_out    = 1'b0;
		idle_check   = 1'b0;
		in_job       = 1'b0;
		start_edge   = 0;
		cur_n        = 0;
		value_errs   = 0;
		timing_errs  = 0;
		timeout_errs = 0;
		repeat (4) @(posedge clk);
		#DRIVE_DLY;
		reset_n = 1'b1;
		@(negedge clk);
		assert (idle && !read && !write && !done && !node_ce && !wgt_ce) else begin
			timing_errs++;
			$display("Control outputs not in their reset state after reset");
		end
		assert (result == '0) else begin
			value_errs++;
			$display("error: o_result = 0x%0h, expected 0x0", result);
		end
		@(posedge clk);
		#DRIVE_DLY;
		// Random count first, then both edge counts, then back to back jobs
		lcg_state = lcg_next(lcg_state);
		n_pick = int'(lcg_state[31:16] % 200) + 1;
		run_job(n_pick);
		if (!timed_out) begin
			run_job(1);
		end
		if (!timed_out) begin
			run_job(DEPTH);
		end
		for (int r = 0; r < 3; r++) begin
			if (!timed_out) begin
				lcg_state = lcg_next(lcg_state);
				n_pick = int'(lcg_state[31:16] % 200) + 1;
				run_job(n_pick);
			end
		end
		$display("Errors: value %0d, timing %0d, timeout %0d",
			value_errs, timing_errs, timeout_errs);
		if (value_errs + timing_errs + timeout_errs == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== fc_layer.f ====
logic/fc_pkg.sv
logic/fc_mac_core.sv
logic/fc_mover_ctrl.sv
logic/fc_layer_top.sv
verification/fc_bram_model.sv
verification/fc_layer_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and judges the run by its log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module fc_layer_tb \
	-f fc_layer.f -o fc_layer_sim \
	&& ./obj_dir/fc_layer_sim > sim.log 2>&1 \
	|| echo "Build or simulation run did not complete"

cat sim.log 2>/dev/null

grep -q "^Simulation passed$" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
